// ==== Makefile ====
TOP := tb_pipe_ctrl
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "no result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
logic/rooth_pkg.sv
logic/branch_cmp.sv
logic/flow_ctrl.sv
logic/pc_gen.sv
logic/stage_track.sv
logic/pipe_ctrl_top.sv
testbench/pipe_ctrl_props.sv
testbench/tb_pipe_ctrl.sv

// ==== logic/branch_cmp.sv ====
// ----------------------------------------------------------
// branch comparator
// equality and less-than of rs1 against rs2, signed unless
// the branch is BLTU or BGEU
// ----------------------------------------------------------
`timescale 1ns/1ps

module branch_cmp (
    input  logic [rooth_pkg::XLEN-1:0] rs1_i,
    input  logic [rooth_pkg::XLEN-1:0] rs2_i,
    input  rooth_pkg::branch_e         branch_i,
    output rooth_pkg::cmp_t            cmp_o
);

    logic is_unsigned;
    logic lt_signed;
    logic lt_unsigned;

    assign is_unsigned = (branch_i == rooth_pkg::BRANCH_BLTU) ||
                         (branch_i == rooth_pkg::BRANCH_BGEU);

    assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
    assign lt_unsigned = rs1_i < rs2_i;

    // flag bundle for the flow controller
    always_comb begin
        cmp_o.zero      = (rs1_i == rs2_i);  // operands equal
        cmp_o.less      = is_unsigned ? lt_unsigned : lt_signed;
        cmp_o.more_zero = ~cmp_o.less;       // greater or equal
    end

endmodule

// ==== logic/flow_ctrl.sv ====
// ----------------------------------------------------------
// pipeline flow controller
// prioritized choice of the stop, work or refresh command
// for each stage, plus the pc redirect for taken branches,
// jumps and interrupts
// ----------------------------------------------------------
`timescale 1ns/1ps

module flow_ctrl (
    input  rooth_pkg::hold_t           hold_i,
    input  rooth_pkg::irq_t            irq_i,
    input  rooth_pkg::branch_e         branch_i,
    input  rooth_pkg::jump_e           jump_i,
    input  rooth_pkg::cmp_t            cmp_i,
    input  logic [rooth_pkg::XLEN-1:0] imm_i,
    input  logic [rooth_pkg::XLEN-1:0] rs1_i,
    input  logic [rooth_pkg::XLEN-1:0] ex_pc_i,    // base for relative targets
    output rooth_pkg::flow_t           flow_o,
    output rooth_pkg::redirect_t       redir_o
);

    logic                       br_cond;
    logic [rooth_pkg::XLEN-1:0] br_target;
    logic [rooth_pkg::XLEN-1:0] jmp_target;

    // pack five commands, pc first
    function automatic rooth_pkg::flow_t flow_set(
        input rooth_pkg::flow_e pc,
        input rooth_pkg::flow_e de,
        input rooth_pkg::flow_e ex,
        input rooth_pkg::flow_e as,
        input rooth_pkg::flow_e wb
    );
        rooth_pkg::flow_t f;
        f.pc = pc;
        f.de = de;
        f.ex = ex;
        f.as = as;
        f.wb = wb;
        return f;
    endfunction

    // ------------------------------------------------------
    // branch condition and targets
    // ------------------------------------------------------
    always_comb begin
        case (branch_i)
            rooth_pkg::BRANCH_BEQ:  br_cond = cmp_i.zero;
            rooth_pkg::BRANCH_BNE:  br_cond = ~cmp_i.zero;
            rooth_pkg::BRANCH_BLT,
            rooth_pkg::BRANCH_BLTU: br_cond = cmp_i.less;
            rooth_pkg::BRANCH_BGE,
            rooth_pkg::BRANCH_BGEU: br_cond = cmp_i.more_zero;
            default:                br_cond = 1'b0;
        endcase
    end

    assign br_target = ex_pc_i + imm_i;

    // bit 0 passes through unmasked
    always_comb begin
        case (jump_i)
            rooth_pkg::JUMP_JALR:  jmp_target = imm_i + rs1_i;
            rooth_pkg::JUMP_FENCE: jmp_target = ex_pc_i + rooth_pkg::PC_STEP;
            default:               jmp_target = ex_pc_i + imm_i;   // jal
        endcase
    end

    // ------------------------------------------------------
    // priority decision, highest first
    // ------------------------------------------------------
    always_comb begin
        flow_o = flow_set(rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_WORK,
                          rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_WORK,
                          rooth_pkg::FLOW_WORK);
        redir_o.taken  = 1'b0;
        redir_o.target = '0;

        if (hold_i.jtag_halt) begin
            flow_o = flow_set(rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                              rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                              rooth_pkg::FLOW_STOP);
        end else if (hold_i.client_hold) begin
            if (irq_i.int_assert) begin      // flush all and enter handler
                flow_o = flow_set(rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_REFRESH,
                                  rooth_pkg::FLOW_REFRESH, rooth_pkg::FLOW_REFRESH,
                                  rooth_pkg::FLOW_REFRESH);
                redir_o.taken  = 1'b1;
                redir_o.target = irq_i.int_addr;
            end else begin
                flow_o = flow_set(rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                                  rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                                  rooth_pkg::FLOW_STOP);
            end
        end else if (hold_i.access_mem_hold) begin
            flow_o = flow_set(rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                              rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                              rooth_pkg::FLOW_REFRESH);
        end else if (hold_i.pr_access_mem) begin
            flow_o = flow_set(rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                              rooth_pkg::FLOW_REFRESH, rooth_pkg::FLOW_WORK,
                              rooth_pkg::FLOW_WORK);
        end else if (hold_i.alu_busy) begin
            flow_o = flow_set(rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_STOP,
                              rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_REFRESH,
                              rooth_pkg::FLOW_WORK);
        end else if (hold_i.bus_wait) begin  // fetch not ready, bubble into decode
            flow_o = flow_set(rooth_pkg::FLOW_STOP, rooth_pkg::FLOW_REFRESH,
                              rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_WORK,
                              rooth_pkg::FLOW_WORK);
        end else if (branch_i != rooth_pkg::BRANCH_NONE) begin
            if (br_cond) begin
                flow_o = flow_set(rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_REFRESH,
                                  rooth_pkg::FLOW_REFRESH, rooth_pkg::FLOW_WORK,
                                  rooth_pkg::FLOW_WORK);
                redir_o.taken  = 1'b1;
                redir_o.target = br_target;
            end
        end else if (jump_i != rooth_pkg::JUMP_NONE) begin
            flow_o = flow_set(rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_REFRESH,
                              rooth_pkg::FLOW_REFRESH, rooth_pkg::FLOW_WORK,
                              rooth_pkg::FLOW_WORK);
            redir_o.taken  = 1'b1;
            redir_o.target = jmp_target;
        end
    end

endmodule

// ==== logic/pc_gen.sv ====
// ----------------------------------------------------------
// fetch program counter
// holds on stop, otherwise steps by 4 or takes the redirect
// ----------------------------------------------------------
`timescale 1ns/1ps

module pc_gen #(
    parameter logic [rooth_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  rooth_pkg::flow_e           flow_pc_i,
    input  rooth_pkg::redirect_t       redir_i,
    output logic [rooth_pkg::XLEN-1:0] pc_o
);

    logic [rooth_pkg::XLEN-1:0] pc_next;

    // redirect wins over the sequential step
    assign pc_next = redir_i.taken ? redir_i.target : pc_o + rooth_pkg::PC_STEP;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else if (flow_pc_i == rooth_pkg::FLOW_WORK) begin
            pc_o <= pc_next;
        end
        // stop keeps the current pc
    end

endmodule

// ==== logic/pipe_ctrl_top.sv ====
// ----------------------------------------------------------
// pipeline control top level
// comparator, flow controller, fetch pc and stage tracker
// ----------------------------------------------------------
`timescale 1ns/1ps

module pipe_ctrl_top #(
    parameter logic [rooth_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  rooth_pkg::hold_t           hold_i,
    input  rooth_pkg::irq_t            irq_i,
    input  rooth_pkg::branch_e         branch_i,
    input  rooth_pkg::jump_e           jump_i,
    input  logic [rooth_pkg::XLEN-1:0] imm_i,
    input  logic [rooth_pkg::XLEN-1:0] rs1_i,
    input  logic [rooth_pkg::XLEN-1:0] rs2_i,
    output logic [rooth_pkg::XLEN-1:0] pc_o,
    output rooth_pkg::flow_t           flow_o,
    output rooth_pkg::stage_t          de_o,
    output rooth_pkg::stage_t          ex_o,
    output rooth_pkg::stage_t          as_o,
    output rooth_pkg::stage_t          wb_o
);

    rooth_pkg::cmp_t      cmp;
    rooth_pkg::redirect_t redir;

    branch_cmp u_branch_cmp (
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .branch_i (branch_i),
        .cmp_o    (cmp)
    );

    flow_ctrl u_flow_ctrl (
        .hold_i   (hold_i),
        .irq_i    (irq_i),
        .branch_i (branch_i),
        .jump_i   (jump_i),
        .cmp_i    (cmp),
        .imm_i    (imm_i),
        .rs1_i    (rs1_i),
        .ex_pc_i  (ex_o.pc),     // execute pc closes the loop
        .flow_o   (flow_o),
        .redir_o  (redir)
    );

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .flow_pc_i (flow_o.pc),
        .redir_i   (redir),
        .pc_o      (pc_o)
    );

    stage_track u_stage_track (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flow_i     (flow_o),
        .fetch_pc_i (pc_o),
        .de_o       (de_o),
        .ex_o       (ex_o),
        .as_o       (as_o),
        .wb_o       (wb_o)
    );

endmodule

// ==== logic/rooth_pkg.sv ====
// ----------------------------------------------------------
// rooth pipeline control package
// flow commands, branch and jump types and the packed
// structs shared by the flow controller and its neighbours
// ----------------------------------------------------------
package rooth_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;  // one instruction word

    // per-stage command
    typedef enum logic [1:0] {
        FLOW_STOP    = 2'd0,  // hold stage contents
        FLOW_WORK    = 2'd1,  // advance
        FLOW_REFRESH = 2'd2   // load a bubble
    } flow_e;

    typedef enum logic [2:0] {
        BRANCH_NONE = 3'd0,
        BRANCH_BEQ  = 3'd1,
        BRANCH_BNE  = 3'd2,
        BRANCH_BLT  = 3'd3,
        BRANCH_BGE  = 3'd4,
        BRANCH_BLTU = 3'd5,
        BRANCH_BGEU = 3'd6
    } branch_e;

    typedef enum logic [1:0] {
        JUMP_NONE  = 2'd0,
        JUMP_JAL   = 2'd1,
        JUMP_JALR  = 2'd2,
        JUMP_FENCE = 2'd3
    } jump_e;

    // ------------------------------------------------------
    // packed bundles
    // ------------------------------------------------------
    typedef struct packed {
        logic jtag_halt;        // debugger halt, top priority
        logic client_hold;
        logic access_mem_hold;
        logic pr_access_mem;
        logic alu_busy;         // multi-cycle divide
        logic bus_wait;
    } hold_t;

    typedef struct packed {
        logic            int_assert;
        logic [XLEN-1:0] int_addr;   // handler entry
    } irq_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic zero;
        logic less;
        logic more_zero;
    } cmp_t;

    typedef struct packed {
        flow_e pc;
        flow_e de;
        flow_e ex;
        flow_e as;
        flow_e wb;
    } flow_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } stage_t;

endpackage

// ==== logic/stage_track.sv ====
// ----------------------------------------------------------
// pipeline stage tracker
// valid bit and pc of decode, execute, access and write back,
// each advanced, held or bubbled by its own flow command
// ----------------------------------------------------------
`timescale 1ns/1ps

module stage_track (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  rooth_pkg::flow_t           flow_i,
    input  logic [rooth_pkg::XLEN-1:0] fetch_pc_i,
    output rooth_pkg::stage_t          de_o,
    output rooth_pkg::stage_t          ex_o,
    output rooth_pkg::stage_t          as_o,
    output rooth_pkg::stage_t          wb_o
);

    rooth_pkg::stage_t fetch_stage;

    // next value of one stage from its command
    function automatic rooth_pkg::stage_t stage_next(
        input rooth_pkg::flow_e  cmd,
        input rooth_pkg::stage_t cur,
        input rooth_pkg::stage_t prev
    );
        rooth_pkg::stage_t nxt;
        nxt = cur;
        case (cmd)
            rooth_pkg::FLOW_WORK:    nxt = prev;           // take upstream
            rooth_pkg::FLOW_REFRESH: nxt.valid = 1'b0;     // bubble, pc kept
            default:                 nxt = cur;
        endcase
        return nxt;
    endfunction

    // fetch slot is always a live instruction
    always_comb begin
        fetch_stage.valid = 1'b1;
        fetch_stage.pc    = fetch_pc_i;
    end

    // ------------------------------------------------------
    // stage registers
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_o <= '0;
            ex_o <= '0;
            as_o <= '0;
            wb_o <= '0;
        end else begin
            de_o <= stage_next(flow_i.de, de_o, fetch_stage);
            ex_o <= stage_next(flow_i.ex, ex_o, de_o);
            as_o <= stage_next(flow_i.as, as_o, ex_o);
            wb_o <= stage_next(flow_i.wb, wb_o, as_o);
        end
    end

endmodule

// ==== testbench/pipe_ctrl_props.sv ====
// ----------------------------------------------------------
// pipeline control properties
// reference flow decision plus one-cycle pc and stage
// expectations, checked at the top-level ports
// ----------------------------------------------------------
`timescale 1ns/1ps

module pipe_ctrl_props #(
    parameter logic [rooth_pkg::XLEN-1:0] RESET_PC = '0
) (
    input logic                       clk,
    input logic                       rst_n_i,
    input rooth_pkg::hold_t           hold_i,
    input rooth_pkg::irq_t            irq_i,
    input rooth_pkg::branch_e         branch_i,
    input rooth_pkg::jump_e           jump_i,
    input logic [rooth_pkg::XLEN-1:0] imm_i,
    input logic [rooth_pkg::XLEN-1:0] rs1_i,
    input logic [rooth_pkg::XLEN-1:0] rs2_i,
    input logic [rooth_pkg::XLEN-1:0] pc_o,
    input rooth_pkg::flow_t           flow_o,
    input rooth_pkg::stage_t          de_o,
    input rooth_pkg::stage_t          ex_o,
    input rooth_pkg::stage_t          as_o,
    input rooth_pkg::stage_t          wb_o
);

    localparam rooth_pkg::flow_e S = rooth_pkg::FLOW_STOP;
    localparam rooth_pkg::flow_e W = rooth_pkg::FLOW_WORK;
    localparam rooth_pkg::flow_e R = rooth_pkg::FLOW_REFRESH;

    int unsigned err_reset = 0;
    int unsigned err_flow  = 0;
    int unsigned err_pc    = 0;
    int unsigned err_stage = 0;

    rooth_pkg::flow_t           exp_flow;
    logic                       exp_taken;
    logic [rooth_pkg::XLEN-1:0] exp_target;
    logic [rooth_pkg::XLEN-1:0] jmp_target;
    logic                       br_true;
    logic                       past_ok;      // one edge out of reset
    logic [rooth_pkg::XLEN-1:0] exp_pc_q;
    rooth_pkg::stage_t [3:0]    exp_st_q;     // de, ex, as, wb

    // work takes upstream, refresh drops valid, stop keeps
    function automatic rooth_pkg::stage_t after_edge(input rooth_pkg::flow_e cmd,
                                                     input rooth_pkg::stage_t cur,
                                                     input rooth_pkg::stage_t prev);
        return (cmd == W) ? {prev.valid, prev.pc} : {cur.valid & (cmd == S), cur.pc};
    endfunction

    // ------------------------------------------------------
    // reference decision
    // ------------------------------------------------------
    always_comb begin
        case (branch_i)
            rooth_pkg::BRANCH_BEQ:  br_true = (rs1_i == rs2_i);
            rooth_pkg::BRANCH_BNE:  br_true = (rs1_i != rs2_i);
            rooth_pkg::BRANCH_BLT:  br_true = ($signed(rs1_i) < $signed(rs2_i));
            rooth_pkg::BRANCH_BGE:  br_true = ($signed(rs1_i) >= $signed(rs2_i));
            rooth_pkg::BRANCH_BLTU: br_true = (rs1_i < rs2_i);
            rooth_pkg::BRANCH_BGEU: br_true = (rs1_i >= rs2_i);
            default:                br_true = 1'b0;
        endcase
        jmp_target = (jump_i == rooth_pkg::JUMP_JALR)  ? imm_i + rs1_i :
                     (jump_i == rooth_pkg::JUMP_FENCE) ? ex_o.pc + 32'd4 : ex_o.pc + imm_i;
    end

    always_comb begin
        exp_flow   = '{pc: W, de: W, ex: W, as: W, wb: W};
        exp_taken  = 1'b0;
        exp_target = '0;
        casez ({hold_i, irq_i.int_assert})   // hold bits, jtag first, then irq
            7'b1??????: exp_flow = '{pc: S, de: S, ex: S, as: S, wb: S};
            7'b01????1: begin
                exp_flow   = '{pc: W, de: R, ex: R, as: R, wb: R};
                exp_taken  = 1'b1;
                exp_target = irq_i.int_addr;
            end
            7'b01????0: exp_flow = '{pc: S, de: S, ex: S, as: S, wb: S};
            7'b001????: exp_flow = '{pc: S, de: S, ex: S, as: S, wb: R};
            7'b0001???: exp_flow = '{pc: S, de: S, ex: R, as: W, wb: W};
            7'b00001??: exp_flow = '{pc: S, de: S, ex: S, as: R, wb: W};
            7'b000001?: exp_flow = '{pc: S, de: R, ex: W, as: W, wb: W};
            default: begin
                if (branch_i != rooth_pkg::BRANCH_NONE) begin
                    if (br_true) begin
                        exp_flow   = '{pc: W, de: R, ex: R, as: W, wb: W};
                        exp_taken  = 1'b1;
                        exp_target = ex_o.pc + imm_i;
                    end
                end else if (jump_i != rooth_pkg::JUMP_NONE) begin
                    exp_flow   = '{pc: W, de: R, ex: R, as: W, wb: W};
                    exp_taken  = 1'b1;
                    exp_target = jmp_target;
                end
            end
        endcase
    end

    // expected state one edge later
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            past_ok  <= 1'b0;
            exp_pc_q <= '0;
            exp_st_q <= '0;
        end else begin
            past_ok     <= 1'b1;
            exp_pc_q    <= (exp_flow.pc == S) ? pc_o :
                           exp_taken ? exp_target : pc_o + 32'd4;
            exp_st_q[3] <= after_edge(exp_flow.de, de_o, {1'b1, pc_o});
            exp_st_q[2] <= after_edge(exp_flow.ex, ex_o, de_o);
            exp_st_q[1] <= after_edge(exp_flow.as, as_o, ex_o);
            exp_st_q[0] <= after_edge(exp_flow.wb, wb_o, as_o);
        end
    end

    // ------------------------------------------------------
    // assertions
    // ------------------------------------------------------
    a_reset_state: assert property (@(posedge clk) $rose(rst_n_i) |->
            (pc_o == RESET_PC) && !(de_o.valid | ex_o.valid | as_o.valid | wb_o.valid))
        else begin
            err_reset++;
            $error("Error %0t pc_o exp %h got %h, valid bits exp 0000 got %b", $time,
                   RESET_PC, pc_o, {de_o.valid, ex_o.valid, as_o.valid, wb_o.valid});
        end

    a_flow: assert property (@(posedge clk) disable iff (!rst_n_i) flow_o == exp_flow)
        else begin
            err_flow++;
            $error("Error %0t flow_o exp %h got %h", $time, exp_flow, flow_o);
        end

    a_pc: assert property (@(posedge clk) disable iff (!rst_n_i) past_ok |-> pc_o == exp_pc_q)
        else begin
            err_pc++;
            $error("Error %0t pc_o exp %h got %h", $time, exp_pc_q, pc_o);
        end

    a_stages: assert property (@(posedge clk) disable iff (!rst_n_i)
            past_ok |-> {de_o, ex_o, as_o, wb_o} == exp_st_q)
        else begin
            err_stage++;
            $error("Error %0t de_o/ex_o/as_o/wb_o exp %h got %h", $time, exp_st_q,
                   {de_o, ex_o, as_o, wb_o});
        end

endmodule

bind pipe_ctrl_top pipe_ctrl_props #(.RESET_PC(RESET_PC)) u_props (.*);

// ==== testbench/tb_pipe_ctrl.sv ====
// ----------------------------------------------------------
// pipeline control testbench
// directed and random stimulus for the bound properties,
// one result line per test and a cycle watchdog
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_pipe_ctrl;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int SEQ_CYC   = 20;
    localparam int BR_ROUNDS = 2;
    localparam int BR_CYC    = 6 * BR_ROUNDS * 4;   // six types of four cycles
    localparam int JMP_CYC   = 9;
    localparam int HOLD_RND  = 40;
    localparam int HOLD_CYC  = 6 * 3 + HOLD_RND;
    localparam int IRQ_CYC   = 16;
    localparam int RUN_CYC   = 16 + SEQ_CYC + BR_CYC + JMP_CYC + HOLD_CYC + IRQ_CYC + 6 * 2;
    localparam int LIMIT_CYC = RUN_CYC * 6 / 5;     // 20 percent margin

    logic                 clk;
    logic                 rst_n_i;
    rooth_pkg::hold_t     hold_i;
    rooth_pkg::irq_t      irq_i;
    rooth_pkg::branch_e   branch_i;
    rooth_pkg::jump_e     jump_i;
    logic [31:0]          imm_i;
    logic [31:0]          rs1_i;
    logic [31:0]          rs2_i;
    logic [31:0]          pc_o;
    rooth_pkg::flow_t     flow_o;
    rooth_pkg::stage_t    de_o;
    rooth_pkg::stage_t    ex_o;
    rooth_pkg::stage_t    as_o;
    rooth_pkg::stage_t    wb_o;

    rooth_pkg::hold_t     h;
    rooth_pkg::irq_t      q;
    logic [31:0]          rnd;
    logic [31:0]          pos;
    logic [31:0]          neg;
    logic [31:0]          imm;
    logic [31:0]          addr;
    int unsigned          mark;
    int unsigned          tests_run;
    int unsigned          tests_failed;
    int unsigned          cycle_cnt;

    pipe_ctrl_top #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk (clk), .rst_n_i (rst_n_i), .hold_i (hold_i), .irq_i (irq_i),
        .branch_i (branch_i), .jump_i (jump_i), .imm_i (imm_i), .rs1_i (rs1_i),
        .rs2_i (rs2_i), .pc_o (pc_o), .flow_o (flow_o), .de_o (de_o), .ex_o (ex_o),
        .as_o (as_o), .wb_o (wb_o)
    );

    always #10 clk = ~clk;

    function automatic int unsigned assertion_errors();
        return dut_i.u_props.err_reset + dut_i.u_props.err_flow +
               dut_i.u_props.err_pc + dut_i.u_props.err_stage;
    endfunction

    // new input values right after the edge and held for one cycle
    task automatic drive_cycle(input rooth_pkg::hold_t hd, input rooth_pkg::irq_t iq,
                               input rooth_pkg::branch_e br, input rooth_pkg::jump_e jp,
                               input logic [31:0] im, input logic [31:0] a,
                               input logic [31:0] b);
        @(posedge clk);
        hold_i   <= hd;
        irq_i    <= iq;
        branch_i <= br;
        jump_i   <= jp;
        imm_i    <= im;
        rs1_i    <= a;
        rs2_i    <= b;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle('0, '0, rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_NONE,
                               '0, '0, '0);
    endtask

    // taken operands first, then not-taken ones
    task automatic branch_pair(input rooth_pkg::branch_e br, input logic [31:0] ta,
                               input logic [31:0] tb, input logic [31:0] na,
                               input logic [31:0] nb);
        drive_cycle('0, '0, br, rooth_pkg::JUMP_NONE, imm, ta, tb);
        idle(1);
        drive_cycle('0, '0, br, rooth_pkg::JUMP_NONE, imm, na, nb);
        idle(1);
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        idle(2);                             // let the last command reach the checks
        errs = assertion_errors() - mark;
        mark = assertion_errors();
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("test %-9s failed, %0d assertion failures", name, errs);
        end else begin
            $display("test %-9s ok", name);
        end
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < LIMIT_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not end within %0d cycles", LIMIT_CYC);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        hold_i       = '0;
        irq_i        = '0;
        branch_i     = rooth_pkg::BRANCH_NONE;
        jump_i       = rooth_pkg::JUMP_NONE;
        imm_i        = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        mark         = 0;
        tests_run    = 0;
        tests_failed = 0;
        rnd = $urandom(83);                  // seed once
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        finish_test("reset");

        idle(SEQ_CYC);
        finish_test("sequence");

        // negative against non-negative splits signed from unsigned
        for (int r = 0; r < BR_ROUNDS; r++) begin
            rnd = $urandom;
            pos = {1'b0, rnd[30:0]};
            rnd = $urandom;
            neg = {1'b1, rnd[30:0]};
            imm = $urandom & 32'h0000_0ffc;
            branch_pair(rooth_pkg::BRANCH_BEQ, pos, pos, pos, neg);
            branch_pair(rooth_pkg::BRANCH_BNE, pos, neg, neg, neg);
            branch_pair(rooth_pkg::BRANCH_BLT, neg, pos, pos, neg);
            branch_pair(rooth_pkg::BRANCH_BGE, pos, neg, neg, pos);
            branch_pair(rooth_pkg::BRANCH_BLTU, pos, neg, neg, pos);
            branch_pair(rooth_pkg::BRANCH_BGEU, neg, pos, pos, neg);
        end
        finish_test("branch");

        addr = $urandom & 32'hffff_fffc;
        drive_cycle('0, '0, rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_JAL, imm, '0, '0);
        idle(2);
        drive_cycle('0, '0, rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_JALR, imm, addr, '0);
        idle(2);
        drive_cycle('0, '0, rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_FENCE, imm, '0, '0);
        idle(2);
        finish_test("jump");

        // each hold alone against a taken branch, then random mixes with jumps
        for (int b = 0; b < 6; b++) begin
            drive_cycle(rooth_pkg::hold_t'(6'b1 << b), '0, rooth_pkg::BRANCH_BEQ,
                        rooth_pkg::JUMP_NONE, imm, pos, pos);
            idle(2);
        end
        for (int n = 0; n < HOLD_RND; n++) begin
            rnd          = $urandom;
            q.int_assert = rnd[6];
            q.int_addr   = {rnd[31:8], 8'h00};
            drive_cycle(rooth_pkg::hold_t'(rnd[5:0]), q,
                        rnd[7] ? rooth_pkg::BRANCH_BEQ : rooth_pkg::BRANCH_NONE,
                        rooth_pkg::jump_e'(rnd[9:8]), imm, pos,
                        rnd[10] ? pos : neg);
        end
        finish_test("hold");

        for (int n = 0; n < 2; n++) begin
            h             = '0;
            h.client_hold = 1'b1;
            q.int_assert  = 1'b1;
            q.int_addr    = $urandom & 32'hffff_fffc;
            drive_cycle(h, q, rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_NONE, '0, '0, '0);
            idle(2);
            q.int_assert = 1'b0;             // same hold without irq freezes the pipeline
            repeat (3) drive_cycle(h, q, rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_NONE,
                                   '0, '0, '0);
            idle(2);
        end
        finish_test("interrupt");

        $display("tests %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, assertion_errors());
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
